// ==== softmax_top.f ====
hw/softmax_pkg.sv
hw/exp_buffer.sv
hw/sum_reducer.sv
hw/fxp_div_pipe.sv
hw/normalizer.sv
hw/softmax_top.sv
verification/tb_softmax_top.sv

// ==== Bender.yml ====
package:
  name: softmax_engine

sources:
  - files:
      - hw/softmax_pkg.sv
      - hw/exp_buffer.sv
      - hw/sum_reducer.sv
      - hw/fxp_div_pipe.sv
      - hw/normalizer.sv
      - hw/softmax_top.sv
  - target: test
    files:
      - verification/tb_softmax_top.sv

// ==== verification/tb_softmax_top.sv ====
`timescale 1ns/1ns

module tb_softmax_top;
  import softmax_pkg::*;

  // requests issued over the whole run with a generous cycle budget each
  localparam int NUM_REQS   = 45;
  localparam int REQ_CYCLES = SUM_LAT + MAX_NODES + DIV_LAT + 20;

  logic    clk;
  logic    rst_n;
  logic    i_valid;
  sm_req_t i_req;
  logic    o_ready;
  sm_rsp_t o_rsp;
  logic    o_done;
  integer  seed;
  int      err_cnt;
  int      check_cnt;
  int      test_cnt;

  softmax_top DUT (
    .clk     (clk),
    .rst_n   (rst_n),
    .i_valid (i_valid),
    .i_req   (i_req),
    .o_ready (o_ready),
    .o_rsp   (o_rsp),
    .o_done  (o_done)
  );

  always #5 clk = ~clk;

  // floor(2^coef_k * 2^15 / sum of 2^coef over the first n nodes)
  function automatic alpha_vec_t model_alpha(coef_vec_t coefs, node_idx_t n);
    longint unsigned total;
    alpha_vec_t      res;
    total = 0;
    res   = '0;
    for (int k = 0; k < n; k++) begin
      total += longint'(1) << coefs[k];
    end
    for (int k = 0; k < n; k++) begin
      res[k] = alpha_t'(((longint'(1) << coefs[k]) << 15) / total);
    end
    return res;
  endfunction

  function automatic sm_req_t random_req(int n);
    sm_req_t req;
    for (int k = 0; k < MAX_NODES; k++) begin
      req.coefs[k] = coef_t'($random(seed));
    end
    req.num_nodes = node_idx_t'(n);
    return req;
  endfunction

  task automatic compare_value(input string what, input logic [131:0] got,
                               input logic [131:0] exp);
    check_cnt++;
    if (got !== exp) begin
      err_cnt++;
      $display("ERROR @ %0t ns: %s mismatch, got %0h expected %0h", $time, what, got, exp);
    end
  endtask

  task automatic report_test(input string name, input int errs_before);
    test_cnt++;
    if (err_cnt == errs_before) begin
      $display("test %s: ok", name);
    end else begin
      $display("test %s: %0d errors", name, err_cnt - errs_before);
    end
  endtask

  // returns on the edge that takes the request
  task automatic send_req(input sm_req_t req);
    @(posedge clk);
    i_valid <= 1'b1;
    i_req   <= req;
    @(posedge clk);
    while (!o_ready) begin
      @(posedge clk);
    end
    i_valid <= 1'b0;
  endtask

  // counts edges from the accept edge to the edge that sees o_done
  task automatic wait_done(output int cycles);
    cycles = 0;
    do begin
      @(posedge clk);
      cycles++;
    end while (!o_done);
  endtask

  // o_done is seen one edge after the edge that raised it
  task automatic check_result(input sm_req_t req, input int cycles);
    compare_value("done latency", cycles - 1,
                  SUM_LAT + 1 + int'(req.num_nodes) + DIV_LAT);
    compare_value("alpha vector", o_rsp.alpha, model_alpha(req.coefs, req.num_nodes));
    compare_value("node count", o_rsp.num_nodes, req.num_nodes);
  endtask

  task automatic run_req(input sm_req_t req);
    int cycles;
    send_req(req);
    wait_done(cycles);
    check_result(req, cycles);
  endtask

  task automatic test_reset_single();
    int      errs;
    sm_req_t req;
    errs = err_cnt;
    compare_value("o_ready after reset", o_ready, 1'b1);
    compare_value("o_done after reset", o_done, 1'b0);
    compare_value("o_rsp after reset", o_rsp, '0);
    req = random_req(1);
    run_req(req);
    compare_value("single node alpha", o_rsp.alpha, {{7{16'h0000}}, 16'h8000});
    report_test("reset_single", errs);
  endtask

  task automatic test_equal_four();
    int      errs;
    sm_req_t req;
    errs = err_cnt;
    req.coefs     = {8{4'd7}};
    req.num_nodes = 4'd4;
    run_req(req);
    compare_value("equal alpha", o_rsp.alpha, {{4{16'h0000}}, {4{16'h2000}}});
    report_test("equal_four", errs);
  endtask

  task automatic test_random_reqs();
    int errs;
    int n;
    errs = err_cnt;
    for (int i = 0; i < 40; i++) begin
      // every count once before the random counts
      n = (i < MAX_NODES) ? i + 1 : 1 + ($unsigned($random(seed)) % MAX_NODES);
      run_req(random_req(n));
    end
    report_test("random_reqs", errs);
  endtask

  task automatic test_held_request();
    int      errs;
    int      cycles;
    sm_req_t req_a;
    sm_req_t req_b;
    sm_rsp_t rsp_a;
    errs  = err_cnt;
    req_a = random_req(5);
    req_b = random_req(3);
    send_req(req_a);
    i_valid <= 1'b1;
    i_req   <= req_b;
    cycles = 0;
    do begin
      @(posedge clk);
      cycles++;
      if (!o_done) begin
        compare_value("o_ready while busy", o_ready, 1'b0);
      end
    end while (!o_done);
    check_result(req_a, cycles);
    // the engine is idle again and this edge takes the held request
    compare_value("o_ready at done", o_ready, 1'b1);
    i_valid <= 1'b0;
    rsp_a.alpha     = model_alpha(req_a.coefs, req_a.num_nodes);
    rsp_a.num_nodes = req_a.num_nodes;
    cycles = 0;
    do begin
      @(posedge clk);
      cycles++;
      if (!o_done) begin
        compare_value("o_rsp held", o_rsp, rsp_a);
      end
    end while (!o_done);
    check_result(req_b, cycles);
    report_test("held_request", errs);
  endtask

  task automatic test_mixed_extremes();
    int      errs;
    int      total;
    sm_req_t req;
    errs          = err_cnt;
    req.coefs     = {4'd15, 4'd0, 4'd0, 4'd0, 4'd0, 4'd15, 4'd0, 4'd15};
    req.num_nodes = 4'd7;
    run_req(req);
    total = 0;
    for (int k = 0; k < MAX_NODES; k++) begin
      total += int'(o_rsp.alpha[k]);
    end
    compare_value("alpha total in range", (total >= 32768 - 7) && (total <= 32768), 1'b1);
    report_test("mixed_extremes", errs);
  endtask

  initial begin
    #((NUM_REQS * REQ_CYCLES + 10) * 10);
    $display("watchdog: the run did not finish in time, DUT appears to hang");
    $display("Simulation failed");
    $finish;
  end

  initial begin
    seed      = 32'h50404ad8;
    err_cnt   = 0;
    check_cnt = 0;
    test_cnt  = 0;
    clk       = 1'b0;
    rst_n     = 1'b0;
    i_valid   = 1'b0;
    i_req     = '0;
    repeat (4) begin
      @(posedge clk);
    end
    rst_n <= 1'b1;
    @(posedge clk);
    test_reset_single();
    test_equal_four();
    test_random_reqs();
    test_held_request();
    test_mixed_extremes();
    $display("tests run: %0d, checks: %0d, errors: %0d", test_cnt, check_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

// ==== hw/softmax_top.sv ====
`timescale 1ns/1ns

module softmax_top (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  i_valid,
  input  softmax_pkg::sm_req_t  i_req,
  output logic                  o_ready,
  output softmax_pkg::sm_rsp_t  o_rsp,
  output logic                  o_done
);
  import softmax_pkg::*;

  logic      accept;
  logic      sum_valid;
  sum_t      sum;
  node_idx_t rd_idx;
  exp_t      rd_exp;

  // exponent lookup for the division stream
  exp_buffer u_exp_buffer (
    .clk      (clk),
    .rst_n    (rst_n),
    .i_accept (accept),
    .i_coefs  (i_req.coefs),
    .i_rd_idx (rd_idx),
    .o_rd_exp (rd_exp)
  );

  // runs alongside the buffer on the same request
  sum_reducer u_sum_reducer (
    .clk         (clk),
    .rst_n       (rst_n),
    .i_accept    (accept),
    .i_coefs     (i_req.coefs),
    .i_num_nodes (i_req.num_nodes),
    .o_sum_valid (sum_valid),
    .o_sum       (sum)
  );

  normalizer u_normalizer (
    .clk         (clk),
    .rst_n       (rst_n),
    .i_valid     (i_valid),
    .i_num_nodes (i_req.num_nodes),
    .o_ready     (o_ready),
    .o_accept    (accept),
    .i_sum_valid (sum_valid),
    .i_sum       (sum),
    .o_rd_idx    (rd_idx),
    .i_rd_exp    (rd_exp),
    .o_rsp       (o_rsp),
    .o_done      (o_done)
  );

endmodule

// ==== hw/normalizer.sv ====
`timescale 1ns/1ns

module normalizer (
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic                   i_valid,
  input  softmax_pkg::node_idx_t i_num_nodes,
  output logic                   o_ready,
  output logic                   o_accept,
  input  logic                   i_sum_valid,
  input  softmax_pkg::sum_t      i_sum,
  output softmax_pkg::node_idx_t o_rd_idx,
  input  softmax_pkg::exp_t      i_rd_exp,
  output softmax_pkg::sm_rsp_t   o_rsp,
  output logic                   o_done
);
  import softmax_pkg::*;

  typedef enum logic [1:0] {IDLE, SUM_WAIT, ISSUE, DRAIN} state_t;

  state_t     state_q;
  node_idx_t  n_q;
  node_idx_t  issue_cnt_q;
  node_idx_t  col_cnt_q;
  logic       div_valid_q;
  exp_t       dividend_q;
  logic       q_valid;
  alpha_t     quotient;
  logic       last_col;
  alpha_vec_t alpha_q;
  alpha_vec_t alpha_nxt;
  sm_rsp_t    rsp_q;
  logic       done_q;

  assign o_ready  = (state_q == IDLE);
  assign o_accept = i_valid && o_ready;
  assign o_rd_idx = issue_cnt_q;
  assign o_rsp    = rsp_q;
  assign o_done   = done_q;

  assign last_col = q_valid && (col_cnt_q == n_q - 1'b1);

  // quotients come back in issue order
  always_comb begin
    alpha_nxt            = alpha_q;
    alpha_nxt[col_cnt_q] = quotient;
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state_q     <= IDLE;
      issue_cnt_q <= '0;
      col_cnt_q   <= '0;
      div_valid_q <= 1'b0;
      done_q      <= 1'b0;
      rsp_q       <= '0;
    end else begin
      div_valid_q <= (state_q == ISSUE);
      done_q      <= last_col;
      case (state_q)
        IDLE: begin
          if (o_accept) begin
            state_q <= SUM_WAIT;
          end
        end
        SUM_WAIT: begin
          if (i_sum_valid) begin
            state_q <= ISSUE;
          end
        end
        ISSUE: begin
          // wrap to zero so the index never leaves the node range
          if (issue_cnt_q == n_q - 1'b1) begin
            issue_cnt_q <= '0;
            state_q     <= DRAIN;
          end else begin
            issue_cnt_q <= issue_cnt_q + 1'b1;
          end
        end
        DRAIN: begin
          if (last_col) begin
            state_q <= IDLE;
          end
        end
        default: state_q <= IDLE;
      endcase
      if (q_valid) begin
        col_cnt_q <= last_col ? '0 : col_cnt_q + 1'b1;
      end
      // response only changes together with the done pulse
      if (last_col) begin
        rsp_q.alpha     <= alpha_nxt;
        rsp_q.num_nodes <= n_q;
      end
    end
  end

  // working vector and divider operand
  always_ff @(posedge clk) begin
    dividend_q <= i_rd_exp;
    if (o_accept) begin
      n_q     <= i_num_nodes;
      alpha_q <= '0;
    end else if (q_valid) begin
      alpha_q <= alpha_nxt;
    end
  end

  // sum is held by sum_reducer for the whole request
  fxp_div_pipe u_div (
    .clk        (clk),
    .rst_n      (rst_n),
    .i_valid    (div_valid_q),
    .i_dividend (dividend_q),
    .i_divisor  (i_sum),
    .o_valid    (q_valid),
    .o_quotient (quotient)
  );

  // divider latency exceeds the longest issue burst
  a_collect_in_drain: assert property (
    @(posedge clk) disable iff (!rst_n)
    q_valid |-> (state_q == DRAIN)
  );

endmodule

// ==== hw/fxp_div_pipe.sv ====
`timescale 1ns/1ns

module fxp_div_pipe (
  input  logic                clk,
  input  logic                rst_n,
  input  logic                i_valid,
  input  softmax_pkg::exp_t   i_dividend,
  input  softmax_pkg::sum_t   i_divisor,
  output logic                o_valid,
  output softmax_pkg::alpha_t o_quotient
);
  import softmax_pkg::*;

  // qs shifts numerator bits out at the top and quotient bits in at the bottom
  typedef struct packed {
    sum_t   rem;
    alpha_t qs;
  } div_step_t;

  logic [DIV_LAT-1:0] vld_q;
  sum_t               rem_q [DIV_LAT-1];
  sum_t               dvs_q [DIV_LAT-1];
  alpha_t             qs_q  [DIV_LAT];
  div_step_t          step  [DIV_LAT];

  // one restoring step
  function automatic div_step_t div_step(sum_t rem, alpha_t qs, sum_t dvs);
    logic [SUM_W:0] trial;
    div_step_t      res;
    trial = {rem, qs[OUT_W-1]};
    if (trial >= {1'b0, dvs}) begin
      trial  = trial - {1'b0, dvs};
      res.qs = {qs[OUT_W-2:0], 1'b1};
    end else begin
      res.qs = {qs[OUT_W-2:0], 1'b0};
    end
    res.rem = trial[SUM_W-1:0];
    return res;
  endfunction

  // numerator is dividend << (OUT_W-1), upper bits start as the remainder
  always_comb begin
    step[0] = div_step(sum_t'(i_dividend >> 1),
                       {i_dividend[0], {(OUT_W-1){1'b0}}}, i_divisor);
    for (int k = 1; k < DIV_LAT; k++) begin
      step[k] = div_step(rem_q[k-1], qs_q[k-1], dvs_q[k-1]);
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      vld_q <= '0;
    end else begin
      vld_q <= {vld_q[DIV_LAT-2:0], i_valid};
    end
  end

  always_ff @(posedge clk) begin
    dvs_q[0] <= i_divisor;
    for (int k = 1; k < DIV_LAT-1; k++) begin
      dvs_q[k] <= dvs_q[k-1];
    end
    // last stage needs no remainder
    for (int k = 0; k < DIV_LAT-1; k++) begin
      rem_q[k] <= step[k].rem;
    end
    for (int k = 0; k < DIV_LAT; k++) begin
      qs_q[k] <= step[k].qs;
    end
  end

  assign o_valid    = vld_q[DIV_LAT-1];
  assign o_quotient = qs_q[DIV_LAT-1];

  a_divisor_nonzero: assert property (
    @(posedge clk) disable iff (!rst_n)
    i_valid |-> (i_divisor != '0)
  );

endmodule

// ==== hw/sum_reducer.sv ====
`timescale 1ns/1ns

module sum_reducer (
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic                   i_accept,
  input  softmax_pkg::coef_vec_t i_coefs,
  input  softmax_pkg::node_idx_t i_num_nodes,
  output logic                   o_sum_valid,
  output softmax_pkg::sum_t      o_sum
);
  import softmax_pkg::*;

  // one valid bit per register level
  logic [SUM_LAT-1:0] vld_q;

  sum_t lvl0_q [MAX_NODES];
  sum_t lvl1_q [MAX_NODES/2];
  sum_t lvl2_q [MAX_NODES/4];
  sum_t lvl3_q;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      vld_q <= '0;
    end else begin
      vld_q <= {vld_q[SUM_LAT-2:0], i_accept};
    end
  end

  // load stage, nodes past the count add nothing
  always_ff @(posedge clk) begin
    if (i_accept) begin
      for (int k = 0; k < MAX_NODES; k++) begin
        if (node_idx_t'(k) < i_num_nodes) begin
          lvl0_q[k] <= sum_t'(1) << i_coefs[k];
        end else begin
          lvl0_q[k] <= '0;
        end
      end
    end
  end

  // pairwise tree, each level enabled by its own valid bit
  always_ff @(posedge clk) begin
    if (vld_q[0]) begin
      for (int k = 0; k < MAX_NODES/2; k++) begin
        lvl1_q[k] <= lvl0_q[2*k] + lvl0_q[2*k+1];
      end
    end
    if (vld_q[1]) begin
      for (int k = 0; k < MAX_NODES/4; k++) begin
        lvl2_q[k] <= lvl1_q[2*k] + lvl1_q[2*k+1];
      end
    end
    // final sum holds until the next request reaches this level
    if (vld_q[2]) begin
      lvl3_q <= lvl2_q[0] + lvl2_q[1];
    end
  end

  assign o_sum_valid = vld_q[SUM_LAT-1];
  assign o_sum       = lvl3_q;

  a_node_count: assert property (
    @(posedge clk) disable iff (!rst_n)
    i_accept |-> (i_num_nodes != '0) && (i_num_nodes <= node_idx_t'(MAX_NODES))
  );

endmodule

// ==== hw/exp_buffer.sv ====
`timescale 1ns/1ns

module exp_buffer (
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic                   i_accept,
  input  softmax_pkg::coef_vec_t i_coefs,
  input  softmax_pkg::node_idx_t i_rd_idx,
  output softmax_pkg::exp_t      o_rd_exp
);
  import softmax_pkg::*;

  coef_vec_t coefs_q;
  coef_t     sel_coef;

  // coefficients stay put for the whole request
  always_ff @(posedge clk) begin
    if (i_accept) begin
      coefs_q <= i_coefs;
    end
  end

  // 2^coef is a one-hot decode of the selected coefficient
  always_comb begin
    sel_coef = coefs_q[i_rd_idx];
    o_rd_exp = '0;
    for (int b = 0; b < EXP_W; b++) begin
      o_rd_exp[b] = (sel_coef == coef_t'(b));
    end
  end

  // the normalizer never steps past the last node slot
  a_rd_idx_range: assert property (
    @(posedge clk) disable iff (!rst_n)
    i_rd_idx < node_idx_t'(MAX_NODES)
  );

endmodule

// ==== hw/softmax_pkg.sv ====
package softmax_pkg;

  localparam int MAX_NODES = 8;
  localparam int COEF_W    = 4;
  localparam int EXP_W     = 16;
  // room for MAX_NODES times 2^15
  localparam int SUM_W     = 19;
  // unsigned 1.15 weights
  localparam int OUT_W     = 16;
  // holds MAX_NODES itself as well as every index
  localparam int NODE_W    = 4;
  // load cycle plus log2(MAX_NODES) adder levels
  localparam int SUM_LAT   = 4;
  // one quotient bit per stage
  localparam int DIV_LAT   = OUT_W;

  typedef logic [COEF_W-1:0] coef_t;
  typedef logic [EXP_W-1:0]  exp_t;
  typedef logic [SUM_W-1:0]  sum_t;
  typedef logic [OUT_W-1:0]  alpha_t;
  typedef logic [NODE_W-1:0] node_idx_t;

  typedef coef_t  [MAX_NODES-1:0] coef_vec_t;
  typedef alpha_t [MAX_NODES-1:0] alpha_vec_t;

  typedef struct packed {
    coef_vec_t coefs;
    node_idx_t num_nodes;
  } sm_req_t;

  typedef struct packed {
    alpha_vec_t alpha;
    node_idx_t  num_nodes;
  } sm_rsp_t;

endpackage
